// File: Makefile
# Verilator flow for the rasterizer sample iterator
# make lint, make sim, make clean

VERILATOR  ?= verilator
TOP        ?= sample_iterator_tb
LINT_TOP   ?= sample_iterator
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Test FAILED
VFLAGS     ?=
LINT_FLAGS ?= -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# Lint the RTL top with every warning enabled
lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) \
		--top-module $(LINT_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

# Run from the project root so the test table path resolves
sim: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulation exited with status $$status"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
rtl/raster_pkg.sv
rtl/sample_step.sv
rtl/box_iter_fsm.sv
rtl/sample_iterator.sv
test/sample_iterator_tb.sv

// File: rtl/box_iter_fsm.sv
// Bounding box iterator control
// Two-state FSM that accepts a triangle, drives the stepper,
// holds the triangle and color, and halts the stage above
`timescale 1ns/100ps

module box_iter_fsm #(
    parameter int SIGFIG = raster_pkg::SIGFIG,
    parameter int VERTS = raster_pkg::VERTS,
    parameter int AXIS = raster_pkg::AXIS,
    parameter int COLORS = raster_pkg::COLORS
) (
    input  logic                       clk,
    input  logic                       rst,

    // Upstream handshake
    input  logic                       valid_tri,

    // Edge flags from the stepper
    input  logic                       at_right,
    input  logic                       at_top,

    // Payload from the bounding box stage
    input  logic signed [SIGFIG-1:0]   tri_in [VERTS-1:0][AXIS-1:0],
    input  logic [SIGFIG-1:0]          color_in [COLORS-1:0],

    // Stepper control
    output logic                       load,
    output logic                       step,

    // Active low halt that freezes upstream while iterating
    output logic                       halt_n,
    output logic                       valid_samp,

    // Payload held for the whole box
    output logic signed [SIGFIG-1:0]   tri_out [VERTS-1:0][AXIS-1:0],
    output logic [SIGFIG-1:0]          color_out [COLORS-1:0]
);

    import raster_pkg::*;

    iter_state_t state;
    iter_state_t state_next;

    // Last sample of the box is on screen this cycle
    logic at_end;

    assign at_end = at_right && at_top;

    // Next state and stepper control
    always_comb begin
        state_next = state;
        load = 1'b0;
        step = 1'b0;
        case (state)
            ITER_WAIT: begin
                // Accept only while idle
                if (valid_tri) begin
                    state_next = ITER_TEST;
                    load = 1'b1;
                end
            end
            ITER_TEST: begin
                if (at_end) begin
                    // Neither load nor step so the stepper parks on lower left
                    state_next = ITER_WAIT;
                end else begin
                    step = 1'b1;
                end
            end
        endcase
    end

    // State plus registered Moore outputs of the next state
    // valid_samp and halt_n flip on the same edge as the state
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state      <= ITER_WAIT;
            valid_samp <= 1'b0;
            halt_n     <= 1'b1;
        end else begin
            state      <= state_next;
            valid_samp <= (state_next == ITER_TEST);
            halt_n     <= (state_next == ITER_WAIT);
        end
    end

    // Triangle and color capture on accept
    // Held unchanged while upstream inputs wander
    always_ff @(posedge clk) begin
        if (load) begin
            tri_out   <= tri_in;
            color_out <= color_in;
        end
    end

endmodule

// File: rtl/raster_pkg.sv
// Raster sample iterator shared definitions
// Fixed-point widths, MSAA subsample encoding and iterator state
package raster_pkg;

    // Fixed-point format for coordinates and color channels
    // Integer part is [SIGFIG-1:RADIX], fraction is [RADIX-1:0]
    localparam int SIGFIG = 24;
    localparam int RADIX = 10;

    // Triangle shape, kept opaque by the iterator
    localparam int VERTS = 3;
    localparam int AXIS = 3;
    localparam int COLORS = 3;

    // One-hot MSAA code
    // 1000 one pixel, 0100 half, 0010 quarter, 0001 eighth
    localparam int SUBSAMP_W = 4;

    // Code bit 3 lands on bit RADIX, i.e. one whole pixel
    localparam int SUBSAMP_SHIFT = RADIX - 3;

    // Signed coordinate
    typedef logic signed [SIGFIG-1:0] coord_t;

    // Unsigned color channel
    typedef logic [SIGFIG-1:0] color_t;

    // Waiting for a triangle, or stepping through its box
    typedef enum logic {
        ITER_WAIT = 1'b0,
        ITER_TEST = 1'b1
    } iter_state_t;

endpackage

// File: rtl/sample_iterator.sv
// Rasterizer sample iterator top level
// Steps one sample per clock across a triangle's bounding box
// at the MSAA rate, holding the triangle and color alongside
`timescale 1ns/100ps

module sample_iterator #(
    parameter int SIGFIG = raster_pkg::SIGFIG,
    parameter int RADIX = raster_pkg::RADIX,
    parameter int VERTS = raster_pkg::VERTS,
    parameter int AXIS = raster_pkg::AXIS,
    parameter int COLORS = raster_pkg::COLORS
) (
    input  logic                              clk,
    input  logic                              rst,

    // From the bounding box stage
    input  logic signed [SIGFIG-1:0]          tri_in [VERTS-1:0][AXIS-1:0],
    input  logic [SIGFIG-1:0]                 color_in [COLORS-1:0],
    input  logic signed [SIGFIG-1:0]          box_in [1:0][1:0],
    input  logic                              valid_tri,
    input  logic [raster_pkg::SUBSAMP_W-1:0]  sub_sample,

    // Back to the bounding box stage
    output logic                              halt_n,

    // To sample test
    output logic signed [SIGFIG-1:0]          tri_out [VERTS-1:0][AXIS-1:0],
    output logic [SIGFIG-1:0]                 color_out [COLORS-1:0],
    output logic signed [SIGFIG-1:0]          sample [1:0],
    output logic                              valid_samp
);

    // FSM to stepper
    logic load;
    logic step;

    // Stepper to FSM
    logic at_right;
    logic at_top;

    sample_step #(
        .SIGFIG     (SIGFIG),
        .RADIX      (RADIX)
    ) sample_step_i (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .step       (step),
        .box_in     (box_in),
        .sub_sample (sub_sample),
        .sample     (sample),
        .at_right   (at_right),
        .at_top     (at_top)
    );

    box_iter_fsm #(
        .SIGFIG     (SIGFIG),
        .VERTS      (VERTS),
        .AXIS       (AXIS),
        .COLORS     (COLORS)
    ) box_iter_fsm_i (
        .clk        (clk),
        .rst        (rst),
        .valid_tri  (valid_tri),
        .at_right   (at_right),
        .at_top     (at_top),
        .tri_in     (tri_in),
        .color_in   (color_in),
        .load       (load),
        .step       (step),
        .halt_n     (halt_n),
        .valid_samp (valid_samp),
        .tri_out    (tri_out),
        .color_out  (color_out)
    );

endmodule

// File: rtl/sample_step.sv
// Sample point stepper for the bounding box iterator
// Holds the box, walks the sample left to right, bottom to top,
// and flags when the sample reaches the right or top edge
`timescale 1ns/100ps

module sample_step #(
    parameter int SIGFIG = raster_pkg::SIGFIG,
    parameter int RADIX = raster_pkg::RADIX
) (
    input  logic                              clk,
    input  logic                              rst,

    // Control from the FSM
    input  logic                              load,
    input  logic                              step,

    // Box corners as [corner][axis] with corner 0 at lower left
    input  logic signed [SIGFIG-1:0]          box_in [1:0][1:0],

    // One-hot MSAA code held static for a triangle
    input  logic [raster_pkg::SUBSAMP_W-1:0]  sub_sample,

    // Current sample with x in [0] and y in [1]
    output logic signed [SIGFIG-1:0]          sample [1:0],
    output logic                              at_right,
    output logic                              at_top
);

    import raster_pkg::*;

    // Package shift assumes the package radix
    // Rebase onto this instance's radix
    localparam int STEP_SHIFT = SUBSAMP_SHIFT + RADIX - raster_pkg::RADIX;

    // Box captured at accept
    logic signed [SIGFIG-1:0] box_q [1:0][1:0];

    // Distance between neighbouring samples
    logic signed [SIGFIG-1:0] step_size;

    // Candidate samples
    logic signed [SIGFIG-1:0] right_x;
    logic signed [SIGFIG-1:0] up_y;
    logic signed [SIGFIG-1:0] sample_next [1:0];

    // Zero-extend the code and shift it into the fraction
    assign step_size = SIGFIG'(sub_sample) << STEP_SHIFT;

    assign right_x = sample[0] + step_size;
    assign up_y    = sample[1] + step_size;

    // Edge compares against the stored upper right corner
    // At-or-beyond so a box not aligned to the step still ends
    assign at_right = (sample[0] >= box_q[1][0]);
    assign at_top   = (sample[1] >= box_q[1][1]);

    // Next sample select
    always_comb begin
        if (load) begin
            // First sample is the lower left corner of the new box
            sample_next[0] = box_in[0][0];
            sample_next[1] = box_in[0][1];
        end else if (step) begin
            if (at_right) begin
                // Wrap back to min x one row up
                sample_next[0] = box_q[0][0];
                sample_next[1] = up_y;
            end else begin
                // One step right on the same row
                sample_next[0] = right_x;
                sample_next[1] = sample[1];
            end
        end else begin
            // Park on the lower left corner when idle or finished
            sample_next[0] = box_q[0][0];
            sample_next[1] = box_q[0][1];
        end
    end

    // Box register
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            box_q <= '{default: '0};
        end else if (load) begin
            box_q <= box_in;
        end
    end

    // Sample register
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sample[0] <= '0;
            sample[1] <= '0;
        end else begin
            sample[0] <= sample_next[0];
            sample[1] <= sample_next[1];
        end
    end

endmodule

// File: test/iter_tests.txt
# min_x min_y max_x max_y code seed hold count
# coords raw fixed point (1024 per pixel), code one-hot binary, seed hex, hold 1 keeps valid_tri high
#
# 1x MSAA, aligned, unaligned and negative boxes
0 0 3072 2048 1000 3a5c71 0 12
100 200 3000 1000 1000 9e0417 0 8
-2048 -1024 1024 0 1000 51b2c8 0 8
0 0 0 3072 1000 6d93aa 0 4
0 0 7168 7168 1000 0f4e26 0 64
#
# Back to back pair at 1x
0 0 2048 1024 1000 c71d05 1 6
1024 0 2048 2048 1000 248f9b 0 6
#
# Half pixel step
0 0 1024 1024 0100 7ae310 0 9
0 0 700 700 0100 b6024d 0 9
-4096 0 4096 0 0100 1c5f83 0 17
#
# Quarter pixel step
512 512 1536 1024 0010 e8a96f 0 15
#
# Eighth pixel step
0 0 512 256 0001 4d7c12 0 15
10 20 300 200 0001 93e0b8 0 12
#
# Degenerate boxes
2048 2048 2048 2048 1000 5f21c6 0 1
-512 300 -512 300 0001 a0d47e 0 1
#
# Chain of three with changing codes, ending on a single sample
0 0 512 512 0100 36b9e1 1 4
-300 -300 0 -300 0010 8c0f5a 1 3
0 0 0 0 1000 e2473d 0 1
#
# Chain at the eighth pixel step
1000 -2000 1100 -1900 0001 71ac94 1 4
0 0 128 128 0001 0b6e2f 0 4

// File: test/sample_iterator_tb.sv
// Testbench for the rasterizer sample iterator
// Reads boxes from a table, models the sample walk and checks order,
// count, step size, payload hold, halt and idle timing
`timescale 1ns/100ps

module sample_iterator_tb;

    import raster_pkg::*;

    localparam int MAX_TESTS = 64;
    // Cycles allowed from presenting a triangle to its first sample
    localparam int WAIT_LIMIT = 16;
    // Upper bound on samples the walk model will produce
    localparam int WALK_LIMIT = 100000;

    logic clk;
    logic rst;

    // DUT inputs
    coord_t tri_in [VERTS-1:0][AXIS-1:0];
    color_t color_in [COLORS-1:0];
    coord_t box_in [1:0][1:0];
    logic valid_tri;
    logic [SUBSAMP_W-1:0] sub_sample;

    // DUT outputs
    logic halt_n;
    coord_t tri_out [VERTS-1:0][AXIS-1:0];
    color_t color_out [COLORS-1:0];
    coord_t sample [1:0];
    logic valid_samp;

    // Test table with one entry per data line
    int num_tests;
    int t_min_x [MAX_TESTS];
    int t_min_y [MAX_TESTS];
    int t_max_x [MAX_TESTS];
    int t_max_y [MAX_TESTS];
    int t_code [MAX_TESTS];
    int t_seed [MAX_TESTS];
    int t_hold [MAX_TESTS];
    int t_count [MAX_TESTS];

    // Expected sample walk of the current box
    int exp_x [$];
    int exp_y [$];

    // Payload presented at accept
    coord_t exp_tri [VERTS-1:0][AXIS-1:0];
    color_t exp_color [COLORS-1:0];

    int error_count;
    int tests_passed;
    int tests_failed;
    logic aborted;

    sample_iterator #(
        .SIGFIG     (SIGFIG),
        .RADIX      (RADIX),
        .VERTS      (VERTS),
        .AXIS       (AXIS),
        .COLORS     (COLORS)
    ) sample_iterator_i (
        .clk        (clk),
        .rst        (rst),
        .tri_in     (tri_in),
        .color_in   (color_in),
        .box_in     (box_in),
        .valid_tri  (valid_tri),
        .sub_sample (sub_sample),
        .halt_n     (halt_n),
        .tri_out    (tri_out),
        .color_out  (color_out),
        .sample     (sample),
        .valid_samp (valid_samp)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Step in raw fixed point for a one-hot code
    // Code bit 3 is one whole pixel and each lower bit halves it
    function automatic int step_for_code(input int code);
        int step;
        case (code)
            8: step = 1 << RADIX;
            4: step = 1 << (RADIX - 1);
            2: step = 1 << (RADIX - 2);
            1: step = 1 << (RADIX - 3);
            default: step = 0;
        endcase
        return step;
    endfunction

    // Reference walk from left to right and bottom to top up to the far corner
    task automatic build_walk(input int idx);
        int x;
        int y;
        int step;
        logic done;
        exp_x.delete();
        exp_y.delete();
        step = step_for_code(t_code[idx]);
        x = t_min_x[idx];
        y = t_min_y[idx];
        done = 1'b0;
        while (!done && exp_x.size() < WALK_LIMIT) begin
            exp_x.push_back(x);
            exp_y.push_back(y);
            if (x >= t_max_x[idx] && y >= t_max_y[idx]) begin
                done = 1'b1;
            end else if (x >= t_max_x[idx]) begin
                x = t_min_x[idx];
                y = y + step;
            end else begin
                x = x + step;
            end
        end
    endtask

    // Read the table
    // Comment lines match no field and drop out
    task automatic load_tests();
        int fd;
        int got;
        int n;
        string line;
        int mnx;
        int mny;
        int mxx;
        int mxy;
        int code;
        int seed;
        int hold;
        int cnt;
        num_tests = 0;
        fd = $fopen("test/iter_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test table test/iter_tests.txt");
            aborted = 1'b1;
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                got = $fgets(line, fd);
                if (got > 0) begin
                    n = $sscanf(line, "%d %d %d %d %b %h %d %d",
                                mnx, mny, mxx, mxy, code, seed, hold, cnt);
                    if (n == 8) begin
                        t_min_x[num_tests] = mnx;
                        t_min_y[num_tests] = mny;
                        t_max_x[num_tests] = mxx;
                        t_max_y[num_tests] = mxy;
                        t_code[num_tests] = code;
                        t_seed[num_tests] = seed;
                        t_hold[num_tests] = hold;
                        t_count[num_tests] = cnt;
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
            if (num_tests == 0) begin
                $display("The test table holds no test lines");
                aborted = 1'b1;
            end
        end
    endtask

    task automatic report_mismatch(input string where, input string name,
                                   input logic [SIGFIG-1:0] expected,
                                   input logic [SIGFIG-1:0] actual);
        $display("** Error %s: %s expected %h got %h", where, name, expected, actual);
        error_count++;
    endtask

    // Idle means no sample and upstream free to move
    task automatic check_idle(input string where);
        if (valid_samp !== 1'b0) begin
            $display("** Error %s: valid_samp expected %h got %h", where, 1'b0, valid_samp);
            error_count++;
        end
        if (halt_n !== 1'b1) begin
            $display("** Error %s: halt_n expected %h got %h", where, 1'b1, halt_n);
            error_count++;
        end
    endtask

    // Present box, code and a fresh payload with valid_tri raised
    task automatic present_triangle(input int idx);
        int v;
        int a;
        int c;
        for (v = 0; v < VERTS; v++) begin
            for (a = 0; a < AXIS; a++) begin
                exp_tri[v][a] = coord_t'($urandom ^ t_seed[idx]);
                tri_in[v][a] <= exp_tri[v][a];
            end
        end
        for (c = 0; c < COLORS; c++) begin
            exp_color[c] = color_t'($urandom ^ t_seed[idx]);
            color_in[c] <= exp_color[c];
        end
        box_in[0][0] <= coord_t'(t_min_x[idx]);
        box_in[0][1] <= coord_t'(t_min_y[idx]);
        box_in[1][0] <= coord_t'(t_max_x[idx]);
        box_in[1][1] <= coord_t'(t_max_y[idx]);
        sub_sample <= SUBSAMP_W'(t_code[idx]);
        valid_tri <= 1'b1;
    endtask

    // Upstream wanders during iteration while the DUT holds its copy
    task automatic scramble_payload();
        int v;
        int a;
        int c;
        for (v = 0; v < VERTS; v++) begin
            for (a = 0; a < AXIS; a++) begin
                tri_in[v][a] <= coord_t'($urandom);
            end
        end
        for (c = 0; c < COLORS; c++) begin
            color_in[c] <= color_t'($urandom);
        end
        box_in[0][0] <= coord_t'($urandom);
        box_in[0][1] <= coord_t'($urandom);
        box_in[1][0] <= coord_t'($urandom);
        box_in[1][1] <= coord_t'($urandom);
    endtask

    // One sample against the walk model and the captured payload
    task automatic check_sample(input int idx, input int k);
        string where;
        int v;
        int a;
        int c;
        where = $sformatf("case %0d sample %0d", idx, k);
        if (sample[0] !== coord_t'(exp_x[k])) begin
            report_mismatch(where, "sample_x", coord_t'(exp_x[k]), sample[0]);
        end
        if (sample[1] !== coord_t'(exp_y[k])) begin
            report_mismatch(where, "sample_y", coord_t'(exp_y[k]), sample[1]);
        end
        if (halt_n !== 1'b0) begin
            $display("** Error %s: halt_n expected %h got %h", where, 1'b0, halt_n);
            error_count++;
        end
        for (v = 0; v < VERTS; v++) begin
            for (a = 0; a < AXIS; a++) begin
                if (tri_out[v][a] !== exp_tri[v][a]) begin
                    report_mismatch(where, $sformatf("tri_out[%0d][%0d]", v, a),
                                    exp_tri[v][a], tri_out[v][a]);
                end
            end
        end
        for (c = 0; c < COLORS; c++) begin
            if (color_out[c] !== exp_color[c]) begin
                report_mismatch(where, $sformatf("color_out[%0d]", c),
                                exp_color[c], color_out[c]);
            end
        end
    endtask

    // Idle cycles with valid_tri low
    task automatic idle_gap(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(posedge clk);
            valid_tri <= 1'b0;
            @(negedge clk);
            check_idle("idle gap");
        end
    endtask

    task automatic run_test(input int idx);
        int errors_before;
        int wait_cycles;
        int k;
        logic got_first;
        logic dropped;
        errors_before = error_count;
        build_walk(idx);
        if (exp_x.size() != t_count[idx]) begin
            $display("Case %0d: table count %0d disagrees with the walk model count %0d",
                     idx, t_count[idx], exp_x.size());
            error_count++;
        end

        @(posedge clk);
        present_triangle(idx);

        // Cycle ahead of the accepting edge is idle like the gap between boxes
        @(negedge clk);
        check_idle($sformatf("case %0d before accept", idx));

        got_first = 1'b0;
        wait_cycles = 0;
        while (!got_first && wait_cycles < WAIT_LIMIT) begin
            @(posedge clk);
            if (t_hold[idx] == 0) begin
                valid_tri <= 1'b0;
            end
            scramble_payload();
            @(negedge clk);
            wait_cycles++;
            got_first = valid_samp;
        end

        k = 0;
        if (!got_first) begin
            $display("Case %0d: no valid sample within %0d cycles of the triangle",
                     idx, WAIT_LIMIT);
            error_count++;
            aborted = 1'b1;
        end else begin
            if (wait_cycles != 1) begin
                $display("Case %0d: first sample came %0d cycles after accept, not 1",
                         idx, wait_cycles);
                error_count++;
            end
            dropped = 1'b0;
            while (k < exp_x.size() && !dropped) begin
                if (k > 0) begin
                    @(posedge clk);
                    scramble_payload();
                    @(negedge clk);
                end
                if (valid_samp !== 1'b1) begin
                    $display("Case %0d: valid_samp dropped after %0d of %0d samples",
                             idx, k, exp_x.size());
                    error_count++;
                    dropped = 1'b1;
                end else begin
                    check_sample(idx, k);
                    k++;
                end
            end
        end

        if (error_count == errors_before) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("case %0d: box (%0d,%0d)-(%0d,%0d) code %b hold %0d, %0d samples, %s",
                 idx, t_min_x[idx], t_min_y[idx], t_max_x[idx], t_max_y[idx],
                 SUBSAMP_W'(t_code[idx]), t_hold[idx], k,
                 (error_count == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        int v;
        int a;
        int c;
        int i;
        int idx;
        rst = 1'b1;
        valid_tri = 1'b0;
        sub_sample = '0;
        for (v = 0; v < VERTS; v++) begin
            for (a = 0; a < AXIS; a++) begin
                tri_in[v][a] = '0;
            end
        end
        for (c = 0; c < COLORS; c++) begin
            color_in[c] = '0;
        end
        box_in = '{default: '0};
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        aborted = 1'b0;
        void'($urandom(94));

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Reset state holds while valid_tri stays low
        for (i = 0; i < 6; i++) begin
            @(negedge clk);
            check_idle("after reset");
            if (sample[0] !== '0) begin
                report_mismatch("after reset", "sample_x", '0, sample[0]);
            end
            if (sample[1] !== '0) begin
                report_mismatch("after reset", "sample_y", '0, sample[1]);
            end
        end

        load_tests();

        idx = 0;
        while (idx < num_tests && !aborted) begin
            run_test(idx);
            // Held valid_tri rolls straight into the next line
            if (!aborted && t_hold[idx] == 0) begin
                idle_gap(1 + int'($urandom % 3));
            end
            idx++;
        end
        if (!aborted) begin
            idle_gap(4);
        end

        $display("%0d cases, %0d passed, %0d failed, %0d errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0 && !aborted) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
